// File: common/gamePkg.sv
package gamePkg;

	//////////////////////////////
	// Timing
	localparam int STEP_CYCLES      = 16;  // Clocks per game step
	localparam int SCROLL_CYCLES    = 64;  // Clocks per welcome shift
	localparam int START_LEN        = 2;
	localparam int MAX_LEN          = 50;  // Entries per bank and winning length
	localparam int STEPS_PER_SYMBOL = 3;
	localparam int PAUSE_STEPS      = 2;   // GOOD or LOSE hold time
	localparam int NUM_BANKS        = 4;

	// Widths
	localparam int SEG_W  = 7;
	localparam int DIGITS = 4;
	localparam int SYM_W  = 3;
	localparam int ADDR_W = 6;

	// Symbol codes
	localparam logic [SYM_W-1:0] SYM_UP    = 3'd0;
	localparam logic [SYM_W-1:0] SYM_DOWN  = 3'd1;
	localparam logic [SYM_W-1:0] SYM_LEFT  = 3'd2;
	localparam logic [SYM_W-1:0] SYM_RIGHT = 3'd3;
	localparam logic [SYM_W-1:0] SYM_MID   = 3'd4;

	//////////////////////////////
	// Glyph words, active low, leftmost digit in the top bits
	localparam logic [DIGITS*SEG_W-1:0] WORD_UP    = 28'b1000001000110011111111111111;
	localparam logic [DIGITS*SEG_W-1:0] WORD_DOWN  = 28'b1000000100000010101011001000;
	localparam logic [DIGITS*SEG_W-1:0] WORD_LEFT  = 28'b1000111000011000011100000111;
	localparam logic [DIGITS*SEG_W-1:0] WORD_RIGHT = 28'b1001100111100100001110000110; // RITE
	localparam logic [DIGITS*SEG_W-1:0] WORD_MID   = 28'b1101010111100110000001111111;
	localparam logic [DIGITS*SEG_W-1:0] WORD_GOOD  = 28'b1000010100000010000000100001;
	localparam logic [DIGITS*SEG_W-1:0] WORD_LOSE  = 28'b1000111100000000100100000110;
	localparam logic [DIGITS*SEG_W-1:0] WORD_BLANK = '1;

	// Welcome string, index 0 enters first
	localparam int WELCOME_LEN = 32;
	localparam logic [0:WELCOME_LEN-1][SEG_W-1:0] WELCOME_TEXT = {
		7'b1010101, 7'b0000110, 7'b1000111, 7'b1000110,  // W E L C
		7'b1000000, 7'b1101010, 7'b0000110, 7'b1111111,  // O M E
		7'b0000111, 7'b1000000, 7'b1111111, 7'b0010010,  // T O   S
		7'b1001111, 7'b1101010, 7'b1000000, 7'b1001000,  // I M O N
		7'b1111111, 7'b0010010, 7'b0100000, 7'b0010001,  // S A Y
		7'b0010010, 7'b1111111, 7'b1111111, 7'b1111111,  // S
		7'b1111111, 7'b1111111, 7'b1111111, 7'b1111111,
		7'b1111111, 7'b1111111, 7'b1111111, 7'b1111111   // Trailing blanks
	};

	// Phase codes
	localparam logic [2:0] PH_IDLE  = 3'd0;
	localparam logic [2:0] PH_SHOW  = 3'd1;
	localparam logic [2:0] PH_GAP   = 3'd2;
	localparam logic [2:0] PH_INPUT = 3'd3;
	localparam logic [2:0] PH_PAUSE = 3'd4;
	localparam logic [2:0] PH_OVER  = 3'd5;

	// Display word, whole or per digit (digit 0 rightmost)
	typedef union packed {
		logic [DIGITS*SEG_W-1:0] word;
		logic [DIGITS-1:0][SEG_W-1:0] digit;
	} dispWord_u;

endpackage

// File: hw/tickGen.sv
module tickGen (
	input  logic clkInit,
	input  logic reset,
	output logic stepTick,
	output logic scrollTick
);
	import gamePkg::*;

	localparam int STEP_W   = $clog2(STEP_CYCLES);
	localparam int SCROLL_W = $clog2(SCROLL_CYCLES);

	logic [STEP_W-1:0]   stepCnt;    // Game step prescaler
	logic [SCROLL_W-1:0] scrollCnt;  // Welcome scroll prescaler

	// Strobes at terminal count
	assign stepTick   = (stepCnt == STEP_W'(STEP_CYCLES - 1));
	assign scrollTick = (scrollCnt == SCROLL_W'(SCROLL_CYCLES - 1));

	always_ff @(posedge clkInit)
	begin
		if (reset)
		begin
			stepCnt   <= '0;
			scrollCnt <= '0;
		end
		else
		begin
			stepCnt   <= stepTick ? '0 : stepCnt + 1'b1;      // Wrap
			scrollCnt <= scrollTick ? '0 : scrollCnt + 1'b1;
		end
	end

endmodule

// File: game/patternRom.sv
module patternRom (
	input  logic                                   clkInit,
	input  logic [$clog2(gamePkg::NUM_BANKS)-1:0] bank,
	input  logic [gamePkg::ADDR_W-1:0]             romAddr,
	output logic [gamePkg::SYM_W-1:0]              expectSym
);
	import gamePkg::*;

	// One row of symbols per bank
	logic [SYM_W-1:0] rom [NUM_BANKS][MAX_LEN];

	//////////////////////////////
	// Table contents

	// Entry k of bank b is (3k + b) mod 5, five symbols in all
	initial
	begin
		for (int b = 0; b < NUM_BANKS; b++)
		begin
			for (int k = 0; k < MAX_LEN; k++)
			begin
				rom[b][k] = SYM_W'((3 * k + b) % 5);
			end
		end
	end

	// Registered read like a block RAM
	always_ff @(posedge clkInit)
	begin
		expectSym <= rom[bank][romAddr];  // One cycle latency
	end

endmodule

// File: game/roundSequencer.sv
module roundSequencer (
	input  logic                                   clkInit,
	input  logic                                   reset,
	input  logic                                   stepTick,
	input  logic                                   start,
	input  logic [$clog2(gamePkg::NUM_BANKS)-1:0] bankIn,
	input  logic [gamePkg::SYM_W-1:0]              expectSym,
	input  logic                                   pressOk,
	input  logic                                   pressBad,
	input  logic [gamePkg::SYM_W-1:0]              pressSym,
	input  logic                                   held,
	output logic [gamePkg::ADDR_W-1:0]             romAddr,
	output logic [$clog2(gamePkg::NUM_BANKS)-1:0] bankSel,
	output logic                                   inputActive,
	output logic                                   roundClear,
	output gamePkg::dispWord_u                     showWord,
	output logic                                   dispSel,
	output logic                                   gameOver,
	output logic [gamePkg::ADDR_W-1:0]             score
);
	import gamePkg::*;

	localparam int TIMER_W = ADDR_W + 2;  // Holds STEPS_PER_SYMBOL * MAX_LEN

	logic [2:0]         phase;
	logic [ADDR_W-1:0]  len;        // Current round length
	logic [ADDR_W-1:0]  idx;        // Playback entry
	logic [ADDR_W-1:0]  okCnt;      // Correct presses so far
	logic [TIMER_W-1:0] timer;      // Steps in input or pause
	logic [TIMER_W-1:0] timeLimit;
	logic               allOk;      // Whole pattern entered
	logic               lost;
	logic               echoOn;     // Echo glyph of last good press

	function automatic dispWord_u symGlyph(input logic [SYM_W-1:0] sym);
		dispWord_u w;
		case (sym)
			SYM_UP:    w.word = WORD_UP;
			SYM_DOWN:  w.word = WORD_DOWN;
			SYM_LEFT:  w.word = WORD_LEFT;
			SYM_RIGHT: w.word = WORD_RIGHT;
			default:   w.word = WORD_MID;
		endcase
		return w;
	endfunction

	assign timeLimit   = TIMER_W'(STEPS_PER_SYMBOL * len);
	assign romAddr     = (phase == PH_INPUT) ? okCnt : idx;  // Expected symbol while entering
	assign inputActive = (phase == PH_INPUT) && !allOk;
	assign dispSel     = (phase == PH_IDLE);                  // Welcome text only in idle

	//////////////////////////////
	// Phase machine
	always_ff @(posedge clkInit)
	begin
		if (reset)
		begin
			phase      <= PH_IDLE;
			len        <= '0;
			idx        <= '0;
			okCnt      <= '0;
			timer      <= '0;
			allOk      <= 1'b0;
			lost       <= 1'b0;
			echoOn     <= 1'b0;
			bankSel    <= '0;
			roundClear <= 1'b0;
			gameOver   <= 1'b0;
			score      <= '0;
		end
		else
		begin
			roundClear <= 1'b0;
			case (phase)
				PH_IDLE, PH_OVER:
				begin
					if (start)
					begin
						bankSel  <= bankIn;             // Bank fixed for the game
						len      <= ADDR_W'(START_LEN);
						idx      <= '0;
						lost     <= 1'b0;
						gameOver <= 1'b0;
						score    <= '0;
						phase    <= PH_GAP;             // Align first show to a step
					end
				end
				PH_SHOW:
				begin
					if (stepTick)
					begin
						if (idx == len - 1'b1)
						begin
							// Last entry shown, no gap
							phase      <= PH_INPUT;
							idx        <= '0;
							okCnt      <= '0;
							timer      <= '0;
							allOk      <= 1'b0;
							echoOn     <= 1'b0;
							roundClear <= 1'b1;
						end
						else
						begin
							phase <= PH_GAP;
							idx   <= idx + 1'b1;  // Next entry fetched during gap
						end
					end
				end
				PH_GAP:
				begin
					if (stepTick)
					begin
						phase <= PH_SHOW;
					end
				end
				PH_INPUT:
				begin
					if (!held)
					begin
						echoOn <= 1'b0;  // Blank on release
					end
					if (pressBad)
					begin
						lost  <= 1'b1;
						timer <= '0;
						phase <= PH_PAUSE;
					end
					else if (pressOk)
					begin
						echoOn <= 1'b1;
						if (okCnt == len - 1'b1)
						begin
							allOk <= 1'b1;
						end
						else
						begin
							okCnt <= okCnt + 1'b1;
						end
					end
					else if (allOk)
					begin
						if (!held)
						begin
							lost  <= 1'b0;  // GOOD after last echo
							timer <= '0;
							phase <= PH_PAUSE;
						end
					end
					else if (stepTick)
					begin
						if (timer == timeLimit - 1'b1)
						begin
							lost  <= 1'b1;  // Time limit
							timer <= '0;
							phase <= PH_PAUSE;
						end
						else
						begin
							timer <= timer + 1'b1;
						end
					end
				end
				PH_PAUSE:
				begin
					if (stepTick)
					begin
						if (timer == TIMER_W'(PAUSE_STEPS - 1))
						begin
							timer <= '0;
							if (lost)
							begin
								phase    <= PH_OVER;
								gameOver <= 1'b1;
								score    <= len - 1'b1;  // Completed length
							end
							else if (len == ADDR_W'(MAX_LEN))
							begin
								phase    <= PH_OVER;  // Win
								gameOver <= 1'b1;
								score    <= len;
							end
							else
							begin
								len   <= len + 1'b1;
								phase <= PH_SHOW;
							end
						end
						else
						begin
							timer <= timer + 1'b1;
						end
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	// Game word
	always_comb
	begin
		case (phase)
			PH_SHOW:  showWord = symGlyph(expectSym);
			PH_INPUT: showWord = echoOn ? symGlyph(pressSym) : WORD_BLANK;
			PH_PAUSE, PH_OVER: showWord = lost ? WORD_LOSE : WORD_GOOD;
			default:  showWord = WORD_BLANK;  // Gap and idle
		endcase
	end

endmodule

// File: game/inputChecker.sv
module inputChecker (
	input  logic                      clkInit,
	input  logic                      reset,
	input  logic                      inputActive,
	input  logic                      roundClear,
	input  logic [gamePkg::SYM_W-1:0] expectSym,
	input  logic                      btnU,
	input  logic                      btnD,
	input  logic                      btnL,
	input  logic                      btnR,
	input  logic                      btnM,
	output logic                      pressOk,
	output logic                      pressBad,
	output logic [gamePkg::SYM_W-1:0] pressSym,
	output logic                      held
);
	import gamePkg::*;

	logic [4:0]       btns;    // Bit position equals symbol code
	logic             anyBtn;
	logic             anyQ;
	logic             multi;   // More than one button
	logic             rise;
	logic [SYM_W-1:0] btnSym;

	assign btns   = {btnM, btnR, btnL, btnD, btnU};
	assign anyBtn = |btns;
	assign multi  = (btns & (btns - 1'b1)) != '0;
	assign rise   = anyBtn && !anyQ;  // New press only after full release
	assign held   = anyQ;

	// One-hot to symbol
	always_comb
	begin
		btnSym = SYM_MID;
		if (btnU) btnSym = SYM_UP;
		else if (btnD) btnSym = SYM_DOWN;
		else if (btnL) btnSym = SYM_LEFT;
		else if (btnR) btnSym = SYM_RIGHT;
	end

	always_ff @(posedge clkInit)
	begin
		if (reset)
		begin
			anyQ     <= 1'b0;
			pressOk  <= 1'b0;
			pressBad <= 1'b0;
		end
		else
		begin
			anyQ     <= anyBtn;
			pressOk  <= 1'b0;
			pressBad <= 1'b0;
			// Nothing counts in the cycle the round opens
			if (inputActive && !roundClear && rise)
			begin
				pressOk  <= !multi && (btnSym == expectSym);
				pressBad <= multi || (btnSym != expectSym);
			end
		end
	end

	// Symbol for the echo
	always_ff @(posedge clkInit)
	begin
		if (rise)
		begin
			pressSym <= btnSym;
		end
	end

endmodule

// File: display/welcomeScroller.sv
module welcomeScroller (
	input  logic               clkInit,
	input  logic               reset,
	input  logic               scrollTick,
	input  logic               active,
	output gamePkg::dispWord_u welcomeWord
);
	import gamePkg::*;

	logic [$clog2(WELCOME_LEN)-1:0] txtIdx;  // Next glyph, wraps at WELCOME_LEN
	logic                           activeQ;

	always_ff @(posedge clkInit)
	begin
		if (reset)
		begin
			txtIdx           <= '0;
			activeQ          <= 1'b0;
			welcomeWord.word <= WORD_BLANK;
		end
		else
		begin
			activeQ <= active;
			if (active && !activeQ)
			begin
				txtIdx           <= '0;  // Restart text
				welcomeWord.word <= WORD_BLANK;
			end
			else if (active && scrollTick)
			begin
				// Shift left, new glyph in at the right
				welcomeWord.digit[DIGITS-1:1] <= welcomeWord.digit[DIGITS-2:0];
				welcomeWord.digit[0]          <= WELCOME_TEXT[txtIdx];
				txtIdx                        <= txtIdx + 1'b1;
			end
		end
	end

endmodule

// File: display/segmentMux.sv
module segmentMux (
	input  logic                       clkInit,
	input  logic                       reset,
	input  logic                       dispSel,
	input  gamePkg::dispWord_u         showWord,
	input  gamePkg::dispWord_u         welcomeWord,
	output logic [gamePkg::DIGITS-1:0] an,
	output logic [gamePkg::SEG_W-1:0]  seg
);
	import gamePkg::*;

	logic [$clog2(DIGITS)-1:0] scanCnt;  // Digit being driven
	dispWord_u                 selWord;

	assign selWord = dispSel ? welcomeWord : showWord;

	//////////////////////////////
	// Digit scan
	always_ff @(posedge clkInit)
	begin
		if (reset)
		begin
			scanCnt <= '0;
			an      <= '1;  // All digits off
			seg     <= '1;
		end
		else
		begin
			scanCnt <= scanCnt + 1'b1;
			an      <= ~(DIGITS'(1) << scanCnt);  // Digit 0 on anode 1110
			seg     <= selWord.digit[scanCnt];
		end
	end

endmodule

// File: hw/simonTop.sv
module simonTop (
	input  logic       clkInit,
	input  logic       reset,
	input  logic       start,
	input  logic [1:0] bank,
	input  logic       btnU,
	input  logic       btnD,
	input  logic       btnL,
	input  logic       btnR,
	input  logic       btnM,
	output logic [3:0] an,
	output logic [6:0] seg,
	output logic       gameOver,
	output logic [5:0] score
);

	logic        stepTick;
	logic        scrollTick;
	logic [5:0]  romAddr;
	logic [1:0]  bankSel;
	logic [2:0]  expectSym;
	logic        inputActive;
	logic        roundClear;
	logic        pressOk;
	logic        pressBad;
	logic [2:0]  pressSym;
	logic        held;
	logic [27:0] showWord;     // Game word
	logic [27:0] welcomeWord;
	logic        dispSel;      // High in idle

	//////////////////////////////
	// Timing and game core
	tickGen uTick (
		.clkInit    (clkInit),
		.reset      (reset),
		.stepTick   (stepTick),
		.scrollTick (scrollTick)
	);

	patternRom uRom (
		.clkInit   (clkInit),
		.bank      (bankSel),
		.romAddr   (romAddr),
		.expectSym (expectSym)
	);

	roundSequencer uSeq (
		.clkInit     (clkInit),
		.reset       (reset),
		.stepTick    (stepTick),
		.start       (start),
		.bankIn      (bank),
		.expectSym   (expectSym),
		.pressOk     (pressOk),
		.pressBad    (pressBad),
		.pressSym    (pressSym),
		.held        (held),
		.romAddr     (romAddr),
		.bankSel     (bankSel),
		.inputActive (inputActive),
		.roundClear  (roundClear),
		.showWord    (showWord),
		.dispSel     (dispSel),
		.gameOver    (gameOver),
		.score       (score)
	);

	inputChecker uChk (
		.clkInit     (clkInit),
		.reset       (reset),
		.inputActive (inputActive),
		.roundClear  (roundClear),
		.expectSym   (expectSym),
		.btnU        (btnU),
		.btnD        (btnD),
		.btnL        (btnL),
		.btnR        (btnR),
		.btnM        (btnM),
		.pressOk     (pressOk),
		.pressBad    (pressBad),
		.pressSym    (pressSym),
		.held        (held)
	);

	// Display path
	welcomeScroller uWelcome (
		.clkInit     (clkInit),
		.reset       (reset),
		.scrollTick  (scrollTick),
		.active      (dispSel),
		.welcomeWord (welcomeWord)
	);

	segmentMux uMux (
		.clkInit     (clkInit),
		.reset       (reset),
		.dispSel     (dispSel),
		.showWord    (showWord),
		.welcomeWord (welcomeWord),
		.an          (an),
		.seg         (seg)
	);

endmodule

// File: verif/simonTb.sv
module simonTb;
	timeunit 1ns;
	timeprecision 100ps;

	import gamePkg::*;

	localparam int NUM_TESTS      = 4;
	localparam int RESET_CYCLES   = 10;
	localparam int PRESS_CYCLES   = 3;
	localparam int RELEASE_CYCLES = 3;
	localparam int WELCOME_WORDS  = 6;      // Windows checked after reset
	localparam logic [15:0] LFSR_SEED = 16'd23005;

	// Fault kinds
	localparam logic [1:0] FAULT_NONE    = 2'd0;
	localparam logic [1:0] FAULT_WRONG   = 2'd1;
	localparam logic [1:0] FAULT_TWO     = 2'd2;
	localparam logic [1:0] FAULT_TIMEOUT = 2'd3;

	typedef struct packed {
		logic [1:0] bank;
		logic [7:0] rounds;  // Rounds played correctly
		logic [1:0] fault;
		logic [5:0] score;   // Expected score
	} testRow_t;

	logic       clkInit;
	logic       reset;
	logic       start;
	logic [1:0] bank;
	logic       btnU;
	logic       btnD;
	logic       btnL;
	logic       btnR;
	logic       btnM;
	logic [3:0] an;
	logic [6:0] seg;
	logic       gameOver;
	logic [5:0] score;

	testRow_t    testTable [NUM_TESTS];
	dispWord_u   asmWord;        // Digits gathered in the current scan
	logic [3:0]  asmMask;
	dispWord_u   prevScan;
	dispWord_u   lastWord;       // Last reported word
	logic        haveWord;
	logic [27:0] wordQ [$];      // Stable words in order
	logic        echoArm;
	logic        echoHit;
	dispWord_u   echoWant;
	logic [15:0] lfsrState;
	int          cycleCount = 0;
	int          cycleLimit;
	int          errCount;
	int          testErrs;
	int          failedTests;

	simonTop UUT (
		.clkInit  (clkInit),
		.reset    (reset),
		.start    (start),
		.bank     (bank),
		.btnU     (btnU),
		.btnD     (btnD),
		.btnL     (btnL),
		.btnR     (btnR),
		.btnM     (btnM),
		.an       (an),
		.seg      (seg),
		.gameOver (gameOver),
		.score    (score)
	);

	initial
	begin
		clkInit = 1'b0;
		forever #50 clkInit = ~clkInit;  // 100 ns period
	end

	// Watchdog
	always @(posedge clkInit)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles without finishing the tests", cycleCount);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////
	// Display monitor
	always @(negedge clkInit)
	begin : sampler
		int digIdx;
		digIdx = -1;
		if (reset)
		begin
			asmMask = '0;
		end
		else
		begin
			for (int d = 0; d < DIGITS; d++)
			begin
				if (an == ~(4'b0001 << d))
					digIdx = d;
			end
		end
		if (digIdx >= 0)
		begin
			asmWord.digit[digIdx] = seg;
			asmMask[digIdx]       = 1'b1;
			if (echoArm && seg != 7'h7f && seg == echoWant.digit[digIdx])
				echoHit = 1'b1;  // Part of the echo glyph seen
			if (asmMask == 4'b1111)
			begin
				asmMask = '0;
				// Two equal scans in a row count as a stable word
				if (asmWord == prevScan && (!haveWord || asmWord != lastWord))
				begin
					wordQ.push_back(asmWord.word);
					lastWord = asmWord;
					haveWord = 1'b1;
				end
				prevScan = asmWord;
			end
		end
	end

	//////////////////////////////
	// Expected values
	function automatic logic [2:0] patternSym(input int b, input int k);
		return 3'((3 * k + b) % 5);
	endfunction

	function automatic logic [27:0] glyphFor(input logic [2:0] sym);
		case (sym)
			3'd0:    return WORD_UP;
			3'd1:    return WORD_DOWN;
			3'd2:    return WORD_LEFT;
			3'd3:    return WORD_RIGHT;
			default: return WORD_MID;
		endcase
	endfunction

	// Display after n shifts, newest glyph on digit 0
	function automatic logic [27:0] windowWord(input int n);
		dispWord_u w;
		int        i;
		for (int d = 0; d < DIGITS; d++)
		begin
			i = n - 1 - d;
			if (i >= 0)
				w.digit[d] = WELCOME_TEXT[i % WELCOME_LEN];
			else
				w.digit[d] = '1;
		end
		return w.word;
	endfunction

	// Taps 16 14 13 11
	function automatic logic lfsrBit();
		logic fb;
		fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function automatic testRow_t makeRow(input int b, input int r, input logic [1:0] f,
		input int s);
		testRow_t row;
		row.bank   = 2'(b);
		row.rounds = 8'(r);
		row.fault  = f;
		row.score  = 6'(s);
		return row;
	endfunction

	function automatic string faultName(input logic [1:0] f);
		case (f)
			FAULT_WRONG:   return "wrong button";
			FAULT_TWO:     return "two buttons";
			FAULT_TIMEOUT: return "timeout";
			default:       return "no fault";
		endcase
	endfunction

	// Steps per round, doubled, plus welcome and reset time
	function automatic int limitCycles();
		int total;
		int len;
		total = (WELCOME_WORDS + 1) * SCROLL_CYCLES + RESET_CYCLES;
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			for (int r = 0; r <= int'(testTable[i].rounds); r++)
			begin
				len   = START_LEN + r;
				total += (2 * len + PAUSE_STEPS + STEPS_PER_SYMBOL * len) * STEP_CYCLES;
			end
			total += RESET_CYCLES;
		end
		return 2 * total;
	endfunction

	//////////////////////////////
	// Stimulus and checks
	task automatic reportMismatch(input string what, input logic [27:0] expected,
		input logic [27:0] got);
		$display("MISMATCH at %0d ns: %s, expected %h, got %h", $time, what, expected, got);
		errCount++;
		testErrs++;
	endtask

	task automatic checkWord(input logic [27:0] expected, input string what);
		logic [27:0] got;
		while (wordQ.size() == 0)
			@(negedge clkInit);
		got = wordQ.pop_front();
		assert (got === expected) else reportMismatch(what, expected, got);
	endtask

	// Gap after start may be too short to show
	task automatic checkFirstGlyph(input logic [27:0] expected);
		logic [27:0] got;
		while (wordQ.size() == 0)
			@(negedge clkInit);
		got = wordQ.pop_front();
		if (got === WORD_BLANK)
		begin
			while (wordQ.size() == 0)
				@(negedge clkInit);
			got = wordQ.pop_front();
		end
		assert (got === expected) else reportMismatch("first glyph", expected, got);
	endtask

	task automatic applyReset();
		@(negedge clkInit);
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clkInit);
		reset = 1'b0;
	endtask

	task automatic startGame(input logic [1:0] b);
		@(negedge clkInit);
		bank  = b;
		start = 1'b1;
		wordQ.delete();
		@(negedge clkInit);
		start = 1'b0;
	endtask

	task automatic pressButtons(input logic [4:0] mask, input logic wantEcho,
		input logic [27:0] echoGlyph);
		@(negedge clkInit);
		echoWant.word = echoGlyph;
		echoHit       = 1'b0;
		echoArm       = wantEcho;
		{btnM, btnR, btnL, btnD, btnU} = mask;
		repeat (PRESS_CYCLES) @(negedge clkInit);
		{btnM, btnR, btnL, btnD, btnU} = '0;
		repeat (RELEASE_CYCLES - 1) @(negedge clkInit);
		@(posedge clkInit);
		echoArm = 1'b0;  // Echo has left seg, next word not sampled yet
		@(negedge clkInit);
		if (wantEcho)
		begin
			assert (echoHit) else
			begin
				$display("Echo glyph was not shown for press %b at %0d ns", mask, $time);
				errCount++;
				testErrs++;
			end
		end
	endtask

	// Entry 0, either after start or after GOOD
	task automatic firstEntry(input int b, input logic first);
		if (first)
		begin
			checkFirstGlyph(glyphFor(patternSym(b, 0)));
			assert (gameOver === 1'b0) else reportMismatch("gameOver after start", 0, gameOver);
		end
		else
		begin
			checkWord(WORD_GOOD, "GOOD message");
			checkWord(glyphFor(patternSym(b, 0)), "entry 0");
		end
	endtask

	task automatic playback(input int b, input int len, input logic first);
		firstEntry(b, first);
		for (int k = 1; k < len; k++)
		begin
			checkWord(WORD_BLANK, "gap");
			checkWord(glyphFor(patternSym(b, k)), $sformatf("entry %0d", k));
		end
		checkWord(WORD_BLANK, "input phase");  // No gap after the last entry
	endtask

	task automatic enterPattern(input int b, input int count);
		logic [2:0] sym;
		for (int k = 0; k < count; k++)
		begin
			sym = patternSym(b, k);
			pressButtons(5'b00001 << sym, 1'b1, glyphFor(sym));
		end
	endtask

	task automatic runTest(input int t);
		testRow_t   row;
		int         lastLen;
		logic [2:0] expSym;
		logic [2:0] wrongSym;
		logic [1:0] pick;
		row      = testTable[t];
		testErrs = 0;
		startGame(row.bank);
		for (int r = 0; r < int'(row.rounds); r++)
		begin
			playback(row.bank, START_LEN + r, r == 0);
			enterPattern(row.bank, START_LEN + r);
		end
		lastLen = START_LEN + int'(row.rounds);
		if (row.fault == FAULT_NONE)
		begin
			firstEntry(row.bank, row.rounds == 0);  // Longer round begins
			assert (gameOver === 1'b0) else reportMismatch("gameOver after GOOD", 0, gameOver);
			applyReset();
		end
		else
		begin
			playback(row.bank, lastLen, row.rounds == 0);
			if (row.fault != FAULT_TIMEOUT)
			begin
				enterPattern(row.bank, lastLen - 1);
				expSym   = patternSym(row.bank, lastLen - 1);
				pick     = {lfsrBit(), lfsrBit()};
				wrongSym = 3'((int'(expSym) + 1 + int'(pick)) % 5);  // Never the expected one
				if (row.fault == FAULT_WRONG)
					pressButtons(5'b00001 << wrongSym, 1'b0, WORD_BLANK);
				else
					pressButtons((5'b00001 << expSym) | (5'b00001 << wrongSym), 1'b0, WORD_BLANK);
			end
			checkWord(WORD_LOSE, "LOSE message");
			while (gameOver !== 1'b1)
				@(negedge clkInit);
			assert (score === row.score) else reportMismatch("final score", row.score, score);
		end
		if (testErrs != 0)
			failedTests++;
		$display("Test %0d: bank %0d, %0d rounds, %s, score %0d: %s", t + 1, row.bank,
			row.rounds, faultName(row.fault), row.score, (testErrs == 0) ? "ok" : "FAILED");
	endtask

	//////////////////////////////
	// Main sequence
	initial
	begin
		reset       = 1'b1;
		start       = 1'b0;
		bank        = 2'd0;
		btnU        = 1'b0;
		btnD        = 1'b0;
		btnL        = 1'b0;
		btnR        = 1'b0;
		btnM        = 1'b0;
		asmMask     = '0;
		haveWord    = 1'b0;
		echoArm     = 1'b0;
		echoHit     = 1'b0;
		lfsrState   = LFSR_SEED;
		errCount    = 0;
		failedTests = 0;

		// Bank, good rounds, fault, score
		testTable[0] = makeRow(2, 1, FAULT_WRONG, 2);
		testTable[1] = makeRow(0, 0, FAULT_TIMEOUT, 1);
		testTable[2] = makeRow(3, 2, FAULT_TWO, 3);   // Restart after game over
		testTable[3] = makeRow(1, 1, FAULT_NONE, 0);  // Ends with reset
		cycleLimit   = limitCycles();

		repeat (RESET_CYCLES) @(negedge clkInit);
		reset = 1'b0;

		// Reset state and welcome scroll
		testErrs = 0;
		assert (gameOver === 1'b0) else reportMismatch("gameOver after reset", 0, gameOver);
		assert (score === 6'd0) else reportMismatch("score after reset", 0, score);
		for (int i = 0; i < WELCOME_WORDS; i++)
			checkWord(windowWord(i), $sformatf("welcome window %0d", i));
		if (testErrs != 0)
			failedTests++;
		$display("Test 0: reset and welcome text: %s", (testErrs == 0) ? "ok" : "FAILED");

		for (int t = 0; t < NUM_TESTS; t++)
			runTest(t);

		$display("Tests run %0d, tests failed %0d, checks failed %0d", NUM_TESTS + 1,
			failedTests, errCount);
		if (errCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: src.f
common/gamePkg.sv
hw/tickGen.sv
game/patternRom.sv
game/roundSequencer.sv
game/inputChecker.sv
display/welcomeScroller.sv
display/segmentMux.sv
hw/simonTop.sv
verif/simonTb.sv

// File: Bender.yml
package:
  name: simon

sources:
  - common/gamePkg.sv
  - hw/tickGen.sv
  - game/patternRom.sv
  - game/roundSequencer.sv
  - game/inputChecker.sv
  - display/welcomeScroller.sv
  - display/segmentMux.sv
  - hw/simonTop.sv
  - target: test
    files:
      - verif/simonTb.sv
